//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= mvm_accel_tb
FILELIST  ?= mvm_accel.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- common/mvm_defines.svh
`ifndef MVM_DEFINES_SVH
`define MVM_DEFINES_SVH

// Matrix geometry, rows and columns stay multiples of the tile edge
`define MVM_ROWS 8
`define MVM_COLS 8
`define MVM_TILE 4

// Q8.8 operands, wide accumulators
`define MVM_DATA_W 16
`define MVM_ACC_W 32
`define MVM_FRAC 8

// One tile load is 16 weights followed by 4 vector elements
`define MVM_TILE_SLOTS 20

`endif

//--- common/mvm_regmap_pkg.sv
package mvm_regmap_pkg;

    localparam int APB_ADDR_W = 12;
    localparam int APB_DATA_W = 32;

    // Control and status
    localparam logic [APB_ADDR_W-1:0] CTRL_OFFSET = 12'h000;
    localparam logic [APB_ADDR_W-1:0] STATUS_OFFSET = 12'h004;
    localparam int CTRL_START_BIT = 0;
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // Weights row-major, then vector, then results, one word each
    localparam logic [APB_ADDR_W-1:0] WEIGHT_BASE = 12'h100;
    localparam logic [APB_ADDR_W-1:0] VECTOR_BASE = 12'h200;
    localparam logic [APB_ADDR_W-1:0] RESULT_BASE = 12'h300;

endpackage

//--- common/mvm_types_pkg.sv
`include "mvm_defines.svh"

package mvm_types_pkg;

    localparam int OPERAND_ADDR_W = $clog2(`MVM_ROWS * `MVM_COLS + `MVM_COLS);
    localparam int RESULT_ADDR_W = $clog2(`MVM_ROWS);
    localparam int SLOT_W = $clog2(`MVM_TILE_SLOTS);
    localparam int COL_W = $clog2(`MVM_TILE);
    // Keep one bit even when there is a single tile row
    localparam int TILE_ROW_W = (`MVM_ROWS / `MVM_TILE > 1) ? $clog2(`MVM_ROWS / `MVM_TILE) : 1;

    typedef logic signed [`MVM_DATA_W-1:0] data_t;
    typedef logic signed [`MVM_ACC_W-1:0] acc_t;
    typedef logic [OPERAND_ADDR_W-1:0] operand_addr_t;
    typedef logic [RESULT_ADDR_W-1:0] result_addr_t;
    typedef logic [SLOT_W-1:0] slot_t;
    typedef logic [COL_W-1:0] col_t;
    typedef logic [TILE_ROW_W-1:0] tile_row_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_FETCH,
        FETCH_WAIT_SPACE,
        FETCH_FINISH
    } fetch_state_e;

    typedef enum logic [1:0] {
        MAC_IDLE,
        MAC_MAC,
        MAC_WRITEBACK
    } mac_state_e;

endpackage

//--- common/tile_if.sv
`timescale 1ns/1ps
`include "mvm_defines.svh"

interface tile_if;

    // Fill side
    logic wr_valid;
    logic wr_ready;
    mvm_types_pkg::slot_t wr_slot;
    mvm_types_pkg::data_t wr_data;
    logic wr_tile_last_in_row;

    // Drain side, one tile column per cycle
    logic rd_valid;
    mvm_types_pkg::data_t rd_weights [`MVM_TILE];
    mvm_types_pkg::data_t rd_x;
    logic rd_last_in_row;
    mvm_types_pkg::tile_row_t rd_tile_row;
    mvm_types_pkg::col_t rd_col;
    logic rd_release;

    modport producer (
        output wr_valid, wr_slot, wr_data, wr_tile_last_in_row,
        input  wr_ready
    );

    modport buffer (
        input  wr_valid, wr_slot, wr_data, wr_tile_last_in_row, rd_col, rd_release,
        output wr_ready, rd_valid, rd_weights, rd_x, rd_last_in_row, rd_tile_row
    );

    modport consumer (
        input  rd_valid, rd_weights, rd_x, rd_last_in_row, rd_tile_row,
        output rd_col, rd_release
    );

endinterface

//--- dv/mvm_accel_asserts.sv
`timescale 1ns/1ps

module mvm_accel_asserts #(
    parameter bit TILE_SIDE = 1'b1
) (
    input logic clk,
    input logic rst_n,
    input logic wr_valid,
    input logic wr_ready,
    input mvm_types_pkg::slot_t wr_slot,
    input mvm_types_pkg::data_t wr_data,
    input logic rd_release,
    input logic rd_valid,
    input logic busy,
    input logic run_done
);

    if (TILE_SIDE) begin : g_tile
        // A slot offered to a full bank stays on the bus until the bank drains
        assert property (@(posedge clk) disable iff (!rst_n)
                         wr_valid && !wr_ready |=>
                         wr_valid && $stable(wr_slot) && $stable(wr_data))
            else $error("tile slot dropped or changed while wr_ready was low");

        assert property (@(posedge clk) disable iff (!rst_n) rd_release |-> rd_valid)
            else $error("rd_release raised while rd_valid was low");
    end else begin : g_host
        // The engine only finishes a run the host started
        assert property (@(posedge clk) disable iff (!rst_n) run_done |-> busy)
            else $error("run_done raised while the host was not busy");
    end

endmodule

bind tile_pingpong_buffer mvm_accel_asserts #(.TILE_SIDE(1'b1)) u_buffer_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid   (tile_bus.wr_valid),
    .wr_ready   (tile_bus.wr_ready),
    .wr_slot    (tile_bus.wr_slot),
    .wr_data    (tile_bus.wr_data),
    .rd_release (tile_bus.rd_release),
    .rd_valid   (tile_bus.rd_valid),
    .busy       (1'b0),
    .run_done   (1'b0)
);

bind mvm_apb_host mvm_accel_asserts #(.TILE_SIDE(1'b0)) u_host_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid   (1'b0),
    .wr_ready   (1'b0),
    .wr_slot    ('0),
    .wr_data    ('0),
    .rd_release (1'b0),
    .rd_valid   (1'b0),
    .busy       (busy),
    .run_done   (run_done)
);

//--- dv/mvm_accel_tb.sv
`timescale 1ns/1ps
`include "mvm_defines.svh"

module mvm_accel_tb;

    localparam int ROWS = `MVM_ROWS;
    localparam int COLS = `MVM_COLS;
    localparam int OPERANDS = ROWS * COLS + COLS;
    localparam int TILES = (ROWS / `MVM_TILE) * (COLS / `MVM_TILE);
    localparam int RESET_CYCLES = 16;
    localparam int NUM_CASES = 5;
    localparam int POLL_LIMIT = TILES * 20;
    // Three cycles per APB transfer, operand write plus readback dominates
    localparam int APB_CYCLES = 3 * (2 * OPERANDS + 2 * ROWS + 16);
    localparam int CYCLE_LIMIT = (NUM_CASES + 2) * (TILES * 40 + APB_CYCLES) + RESET_CYCLES;
    localparam logic [31:0] STAT_BUSY = 32'(1) << mvm_regmap_pkg::STATUS_BUSY_BIT;
    localparam logic [31:0] STAT_DONE = 32'(1) << mvm_regmap_pkg::STATUS_DONE_BIT;

    // Weight pattern 0 identity, 1 all ones, 2 random, 3 extremes
    // Vector pattern 0 ramp, 1 random, 2 extremes
    typedef struct packed {
        logic [1:0] wpat;
        logic [1:0] vpat;
        logic [31:0] exp_status;
    } case_t;

    localparam case_t CASES [NUM_CASES] = '{
        '{2'd0, 2'd0, STAT_DONE},
        '{2'd1, 2'd0, STAT_DONE},
        '{2'd2, 2'd1, STAT_DONE},
        '{2'd3, 2'd2, STAT_DONE},
        '{2'd2, 2'd2, STAT_DONE}
    };

    logic clk;
    logic rst_n;
    logic psel;
    logic penable;
    logic pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    logic signed [15:0] w_mem [ROWS][COLS];
    logic signed [15:0] x_mem [COLS];
    logic signed [31:0] exp_res [ROWS];
    logic [31:0] rng;
    logic [31:0] rdata;
    logic err;
    int errors;
    int checks;
    int cycles;

    mvm_accel_top uut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("ERROR: simulation did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got 0x%08h expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // One zero wait state transfer, response sampled mid access phase
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata);
        @(posedge clk);
        #2;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        check_equal("pready in access phase", 32'(pready), 32'd1);
        @(posedge clk);
        #2;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic load_operands(input logic [1:0] wpat, input logic [1:0] vpat);
        logic [11:0] addr;
        logic signed [31:0] word;
        logic signed [31:0] prod;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                rng = xorshift32(rng);
                case (wpat)
                    2'd0: w_mem[r][c] = (r == c) ? 16'sh0100 : 16'sh0000;
                    2'd1: w_mem[r][c] = 16'sh0100;
                    2'd2: w_mem[r][c] = rng[15:0];
                    default: w_mem[r][c] = ((r + c) % 2 == 1) ? 16'sh8000 : 16'sh7fff;
                endcase
            end
        end
        for (int c = 0; c < COLS; c++) begin
            rng = xorshift32(rng);
            case (vpat)
                2'd0: x_mem[c] = 16'(c * 96 - 200);
                2'd1: x_mem[c] = rng[31:16];
                default: x_mem[c] = (c % 2 == 0) ? 16'sh8000 : 16'sh7fff;
            endcase
        end
        for (int i = 0; i < OPERANDS; i++) begin
            if (i < ROWS * COLS) begin
                addr = mvm_regmap_pkg::WEIGHT_BASE + 12'(4 * i);
                word = w_mem[i / COLS][i % COLS];
            end else begin
                addr = mvm_regmap_pkg::VECTOR_BASE + 12'(4 * (i - ROWS * COLS));
                word = x_mem[i - ROWS * COLS];
            end
            apb_xfer(1'b1, addr, word);
            check_equal("operand write pslverr", 32'(err), 32'd0);
            apb_xfer(1'b0, addr, 32'd0);
            check_equal($sformatf("operand readback 0x%03h", addr), rdata, word);
        end
        // Each Q8.8 product is realigned on its own before the row sum
        for (int r = 0; r < ROWS; r++) begin
            exp_res[r] = 0;
            for (int c = 0; c < COLS; c++) begin
                prod = 32'(w_mem[r][c]) * 32'(x_mem[c]);
                exp_res[r] = exp_res[r] + (prod >>> 8);
            end
        end
    endtask

    task automatic start_run();
        apb_xfer(1'b1, mvm_regmap_pkg::CTRL_OFFSET, 32'(1) << mvm_regmap_pkg::CTRL_START_BIT);
        check_equal("start pslverr", 32'(err), 32'd0);
        apb_xfer(1'b0, mvm_regmap_pkg::STATUS_OFFSET, 32'd0);
        check_equal("status after start", rdata, STAT_BUSY);
    endtask

    task automatic wait_done();
        int polls;
        polls = 0;
        rdata = STAT_BUSY;
        while (rdata[mvm_regmap_pkg::STATUS_BUSY_BIT] && polls < POLL_LIMIT) begin
            apb_xfer(1'b0, mvm_regmap_pkg::STATUS_OFFSET, 32'd0);
            polls++;
        end
        if (rdata[mvm_regmap_pkg::STATUS_BUSY_BIT]) begin
            errors++;
            $display("ERROR: run still busy after %0d status polls", POLL_LIMIT);
        end
    endtask

    task automatic expect_results();
        for (int r = 0; r < ROWS; r++) begin
            apb_xfer(1'b0, mvm_regmap_pkg::RESULT_BASE + 12'(4 * r), 32'd0);
            check_equal($sformatf("result row %0d", r), rdata, exp_res[r]);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rng = 32'd5205;
        errors = 0;
        checks = 0;
        cycles = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst_n = 1'b1;

        check_equal("pslverr after reset", 32'(pslverr), 32'd0);
        apb_xfer(1'b0, mvm_regmap_pkg::STATUS_OFFSET, 32'd0);
        check_equal("status after reset", rdata, 32'd0);
        check_equal("status read pslverr", 32'(err), 32'd0);
        for (int r = 0; r < ROWS; r++) begin
            apb_xfer(1'b0, mvm_regmap_pkg::RESULT_BASE + 12'(4 * r), 32'd0);
            check_equal($sformatf("result row %0d after reset", r), rdata, 32'd0);
        end

        for (int i = 0; i < NUM_CASES; i++) begin
            load_operands(CASES[i].wpat, CASES[i].vpat);
            start_run();
            wait_done();
            check_equal($sformatf("status after case %0d", i), rdata, CASES[i].exp_status);
            expect_results();
        end

        // Rerun on the operands already in memory
        start_run();
        wait_done();
        check_equal("status after rerun", rdata, STAT_DONE);
        expect_results();

        // Writes made during a run are refused or ignored
        load_operands(2'd2, 2'd1);
        start_run();
        apb_xfer(1'b1, mvm_regmap_pkg::WEIGHT_BASE, 32'h0000_1234);
        check_equal("weight write while busy pslverr", 32'(err), 32'd1);
        apb_xfer(1'b1, mvm_regmap_pkg::CTRL_OFFSET, 32'd1);
        check_equal("start while busy pslverr", 32'(err), 32'd0);
        wait_done();
        check_equal("status after guarded run", rdata, STAT_DONE);
        expect_results();
        apb_xfer(1'b0, mvm_regmap_pkg::WEIGHT_BASE, 32'd0);
        check_equal("weight after refused write", rdata, 32'(w_mem[0][0]));
        apb_xfer(1'b0, 12'h008, 32'd0);
        check_equal("unmapped read pslverr", 32'(err), 32'd1);
        apb_xfer(1'b1, mvm_regmap_pkg::RESULT_BASE, 32'hdead_beef);
        check_equal("result write pslverr", 32'(err), 32'd1);
        apb_xfer(1'b0, mvm_regmap_pkg::RESULT_BASE, 32'd0);
        check_equal("result after refused write", rdata, exp_res[0]);

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- hw/mvm_accel_top.sv
`timescale 1ns/1ps

module mvm_accel_top (
    input  logic clk,
    input  logic rst_n,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [mvm_regmap_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [mvm_regmap_pkg::APB_DATA_W-1:0] pwdata,
    output logic [mvm_regmap_pkg::APB_DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr
);

    logic start;
    logic op_rd_en;
    mvm_types_pkg::operand_addr_t op_rd_addr;
    mvm_types_pkg::data_t op_rd_data;
    logic res_we;
    mvm_types_pkg::result_addr_t res_addr;
    mvm_types_pkg::acc_t res_data;
    logic run_done;

    tile_if tile_bus ();

    mvm_apb_host u_host (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .start      (start),
        .op_rd_en   (op_rd_en),
        .op_rd_addr (op_rd_addr),
        .op_rd_data (op_rd_data),
        .res_we     (res_we),
        .res_addr   (res_addr),
        .res_data   (res_data),
        .run_done   (run_done)
    );

    tile_fetcher u_fetcher (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op_rd_en   (op_rd_en),
        .op_rd_addr (op_rd_addr),
        .op_rd_data (op_rd_data),
        .tile_bus   (tile_bus.producer)
    );

    tile_pingpong_buffer u_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .tile_bus   (tile_bus.buffer)
    );

    tile_mac_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .tile_bus   (tile_bus.consumer),
        .res_we     (res_we),
        .res_addr   (res_addr),
        .res_data   (res_data),
        .run_done   (run_done)
    );

endmodule

//--- hw/mvm_apb_host.sv
`timescale 1ns/1ps
`include "mvm_defines.svh"

module mvm_apb_host (
    input  logic clk,
    input  logic rst_n,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [mvm_regmap_pkg::APB_ADDR_W-1:0] paddr,
    input  logic [mvm_regmap_pkg::APB_DATA_W-1:0] pwdata,
    output logic [mvm_regmap_pkg::APB_DATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic start,
    input  logic op_rd_en,
    input  mvm_types_pkg::operand_addr_t op_rd_addr,
    output mvm_types_pkg::data_t op_rd_data,
    input  logic res_we,
    input  mvm_types_pkg::result_addr_t res_addr,
    input  mvm_types_pkg::acc_t res_data,
    input  logic run_done
);

    localparam int AW = mvm_regmap_pkg::APB_ADDR_W;
    localparam int DW = mvm_regmap_pkg::APB_DATA_W;
    localparam int WEIGHTS = `MVM_ROWS * `MVM_COLS;
    localparam int OPERANDS = WEIGHTS + `MVM_COLS;

    mvm_types_pkg::data_t op_mem [OPERANDS];
    mvm_types_pkg::acc_t res_mem [`MVM_ROWS];
    logic busy;
    logic done;
    logic access;
    logic wr_access;
    logic op_we;
    logic hit_ctrl;
    logic hit_status;
    logic hit_weight;
    logic hit_vector;
    logic hit_result;
    logic [AW-1:0] wgt_off;
    logic [AW-1:0] vec_off;
    logic [AW-1:0] res_off;
    mvm_types_pkg::operand_addr_t op_apb_addr;
    mvm_types_pkg::result_addr_t res_apb_addr;

    assign access = psel && penable;
    assign wr_access = access && pwrite;

    // Offsets wrap below a base, so one compare bounds each region
    assign wgt_off = paddr - mvm_regmap_pkg::WEIGHT_BASE;
    assign vec_off = paddr - mvm_regmap_pkg::VECTOR_BASE;
    assign res_off = paddr - mvm_regmap_pkg::RESULT_BASE;

    assign hit_ctrl = paddr == mvm_regmap_pkg::CTRL_OFFSET;
    assign hit_status = paddr == mvm_regmap_pkg::STATUS_OFFSET;
    assign hit_weight = (wgt_off < AW'(4 * WEIGHTS)) && (paddr[1:0] == 2'b00);
    assign hit_vector = (vec_off < AW'(4 * `MVM_COLS)) && (paddr[1:0] == 2'b00);
    assign hit_result = (res_off < AW'(4 * `MVM_ROWS)) && (paddr[1:0] == 2'b00);

    assign op_apb_addr = hit_weight ? mvm_types_pkg::operand_addr_t'(wgt_off >> 2)
                                    : mvm_types_pkg::operand_addr_t'(WEIGHTS + (vec_off >> 2));
    assign res_apb_addr = mvm_types_pkg::result_addr_t'(res_off >> 2);

    // Operands are frozen while a run is in progress
    assign op_we = wr_access && (hit_weight || hit_vector) && !busy;
    assign start = wr_access && hit_ctrl && pwdata[mvm_regmap_pkg::CTRL_START_BIT] && !busy;

    assign pready = 1'b1;
    assign pslverr = access && (!(hit_ctrl || hit_status || hit_weight || hit_vector || hit_result)
                                || (pwrite && hit_result)
                                || (pwrite && busy && (hit_weight || hit_vector)));

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_status) begin
                prdata[mvm_regmap_pkg::STATUS_BUSY_BIT] = busy;
                prdata[mvm_regmap_pkg::STATUS_DONE_BIT] = done;
            end else if (hit_weight || hit_vector) begin
                prdata = DW'(op_mem[op_apb_addr]);
            end else if (hit_result) begin
                prdata = DW'(res_mem[res_apb_addr]);
            end
        end
    end

    // Done is sticky until the next accepted start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            done <= 1'b0;
        end else if (run_done) begin
            busy <= 1'b0;
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MVM_ROWS; i++) begin
                res_mem[i] <= '0;
            end
        end else if (res_we) begin
            res_mem[res_addr] <= res_data;
        end
    end

    // Read data holds between fetcher reads
    always_ff @(posedge clk) begin
        if (op_we) begin
            op_mem[op_apb_addr] <= mvm_types_pkg::data_t'(pwdata[`MVM_DATA_W-1:0]);
        end
        if (op_rd_en) begin
            op_rd_data <= op_mem[op_rd_addr];
        end
    end

endmodule

//--- mvm_accel.f
+incdir+common
common/mvm_types_pkg.sv
common/mvm_regmap_pkg.sv
common/tile_if.sv
hw/mvm_apb_host.sv
tile_engine/tile_fetcher.sv
tile_engine/tile_pingpong_buffer.sv
tile_engine/tile_mac_engine.sv
hw/mvm_accel_top.sv
dv/mvm_accel_asserts.sv
dv/mvm_accel_tb.sv

//--- tile_engine/tile_fetcher.sv
`timescale 1ns/1ps
`include "mvm_defines.svh"

module tile_fetcher (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic op_rd_en,
    output mvm_types_pkg::operand_addr_t op_rd_addr,
    input  mvm_types_pkg::data_t op_rd_data,
    tile_if.producer tile_bus
);

    localparam int TILE_COLS = `MVM_COLS / `MVM_TILE;
    localparam int TILE_ROWS = `MVM_ROWS / `MVM_TILE;
    localparam int WEIGHTS = `MVM_TILE * `MVM_TILE;
    localparam int TC_W = (TILE_COLS > 1) ? $clog2(TILE_COLS) : 1;

    mvm_types_pkg::fetch_state_e state;
    mvm_types_pkg::slot_t slot;
    mvm_types_pkg::tile_row_t tile_r;
    logic [TC_W-1:0] tile_c;
    logic pend;
    mvm_types_pkg::slot_t pend_slot;
    logic pend_last;
    logic stage_free;
    logic issue;
    logic last_slot;
    logic last_col;
    logic last_tile;

    // The returned word waits in the output stage until the buffer takes it
    assign stage_free = !pend || tile_bus.wr_ready;
    assign issue = ((state == mvm_types_pkg::FETCH_FETCH) ||
                    (state == mvm_types_pkg::FETCH_WAIT_SPACE)) && stage_free;
    assign last_slot = slot == mvm_types_pkg::slot_t'(`MVM_TILE_SLOTS - 1);
    assign last_col = tile_c == TC_W'(TILE_COLS - 1);
    assign last_tile = last_col && (tile_r == mvm_types_pkg::tile_row_t'(TILE_ROWS - 1));

    assign op_rd_en = issue;
    assign tile_bus.wr_valid = pend;
    assign tile_bus.wr_slot = pend_slot;
    assign tile_bus.wr_data = op_rd_data;
    assign tile_bus.wr_tile_last_in_row = pend_last;

    // Weight slots are row-major inside the tile, vector slots follow
    always_comb begin
        int unsigned row;
        int unsigned col;
        row = tile_r * `MVM_TILE + slot / `MVM_TILE;
        col = tile_c * `MVM_TILE + slot % `MVM_TILE;
        if (slot < WEIGHTS) begin
            op_rd_addr = mvm_types_pkg::operand_addr_t'(row * `MVM_COLS + col);
        end else begin
            op_rd_addr = mvm_types_pkg::operand_addr_t'(`MVM_ROWS * `MVM_COLS
                                                       + tile_c * `MVM_TILE + slot - WEIGHTS);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mvm_types_pkg::FETCH_IDLE;
            slot <= '0;
            tile_r <= '0;
            tile_c <= '0;
            pend <= 1'b0;
            pend_slot <= '0;
            pend_last <= 1'b0;
        end else begin
            if (issue) begin
                pend <= 1'b1;
                pend_slot <= slot;
                pend_last <= last_col;
            end else if (tile_bus.wr_ready) begin
                pend <= 1'b0;
            end

            // Tiles go across a tile row before moving down
            if (issue) begin
                if (last_slot) begin
                    slot <= '0;
                    if (last_col) begin
                        tile_c <= '0;
                        tile_r <= tile_r + 1'b1;
                    end else begin
                        tile_c <= tile_c + 1'b1;
                    end
                end else begin
                    slot <= slot + 1'b1;
                end
            end

            case (state)
                mvm_types_pkg::FETCH_IDLE: begin
                    if (start) begin
                        state <= mvm_types_pkg::FETCH_FETCH;
                        slot <= '0;
                        tile_r <= '0;
                        tile_c <= '0;
                    end
                end
                mvm_types_pkg::FETCH_FETCH, mvm_types_pkg::FETCH_WAIT_SPACE: begin
                    if (issue && last_slot && last_tile) begin
                        state <= mvm_types_pkg::FETCH_FINISH;
                    end else if (issue) begin
                        state <= mvm_types_pkg::FETCH_FETCH;
                    end else begin
                        state <= mvm_types_pkg::FETCH_WAIT_SPACE;
                    end
                end
                mvm_types_pkg::FETCH_FINISH: begin
                    // Last word still has to land in the buffer
                    if (stage_free) begin
                        state <= mvm_types_pkg::FETCH_IDLE;
                    end
                end
                default: state <= mvm_types_pkg::FETCH_IDLE;
            endcase
        end
    end

endmodule

//--- tile_engine/tile_mac_engine.sv
`timescale 1ns/1ps
`include "mvm_defines.svh"

module tile_mac_engine (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    tile_if.consumer tile_bus,
    output logic res_we,
    output mvm_types_pkg::result_addr_t res_addr,
    output mvm_types_pkg::acc_t res_data,
    output logic run_done
);

    localparam int TILES = (`MVM_ROWS / `MVM_TILE) * (`MVM_COLS / `MVM_TILE);
    localparam int CNT_W = $clog2(TILES + 1);

    mvm_types_pkg::mac_state_e state;
    mvm_types_pkg::col_t col;
    mvm_types_pkg::col_t wb_idx;
    mvm_types_pkg::tile_row_t row_tag;
    mvm_types_pkg::acc_t acc [`MVM_TILE];
    mvm_types_pkg::acc_t lane_sum [`MVM_TILE];
    logic [CNT_W-1:0] tiles_done;
    logic mac_fire;
    logic tile_end;
    logic wb_end;
    logic acc_clear;

    assign mac_fire = (state == mvm_types_pkg::MAC_MAC) && tile_bus.rd_valid;
    assign tile_end = mac_fire && (col == mvm_types_pkg::col_t'(`MVM_TILE - 1));
    assign wb_end = (state == mvm_types_pkg::MAC_WRITEBACK) &&
                    (wb_idx == mvm_types_pkg::col_t'(`MVM_TILE - 1));
    assign acc_clear = ((state == mvm_types_pkg::MAC_IDLE) && start) || wb_end;

    // Bank goes back to the fetcher with the fourth column
    assign tile_bus.rd_col = col;
    assign tile_bus.rd_release = tile_end;

    assign res_we = state == mvm_types_pkg::MAC_WRITEBACK;
    assign res_addr = mvm_types_pkg::result_addr_t'(row_tag * `MVM_TILE + wb_idx);
    assign res_data = acc[wb_idx];

    // Q8.8 product realigned before it joins the row sum
    always_comb begin
        for (int i = 0; i < `MVM_TILE; i++) begin
            lane_sum[i] = acc[i] + ((mvm_types_pkg::acc_t'(tile_bus.rd_weights[i])
                                     * mvm_types_pkg::acc_t'(tile_bus.rd_x)) >>> `MVM_FRAC);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `MVM_TILE; i++) begin
            if (acc_clear) begin
                acc[i] <= '0;
            end else if (mac_fire) begin
                acc[i] <= lane_sum[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mvm_types_pkg::MAC_IDLE;
            col <= '0;
            wb_idx <= '0;
            row_tag <= '0;
            tiles_done <= '0;
            run_done <= 1'b0;
        end else begin
            run_done <= 1'b0;
            case (state)
                mvm_types_pkg::MAC_IDLE: begin
                    if (start) begin
                        state <= mvm_types_pkg::MAC_MAC;
                        col <= '0;
                        tiles_done <= '0;
                    end
                end
                mvm_types_pkg::MAC_MAC: begin
                    if (tile_end) begin
                        col <= '0;
                        tiles_done <= tiles_done + 1'b1;
                        // Tag is latched now, the bank is gone next cycle
                        if (tile_bus.rd_last_in_row) begin
                            state <= mvm_types_pkg::MAC_WRITEBACK;
                            wb_idx <= '0;
                            row_tag <= tile_bus.rd_tile_row;
                        end
                    end else if (mac_fire) begin
                        col <= col + 1'b1;
                    end
                end
                mvm_types_pkg::MAC_WRITEBACK: begin
                    wb_idx <= wb_idx + 1'b1;
                    if (wb_end) begin
                        if (tiles_done == CNT_W'(TILES)) begin
                            state <= mvm_types_pkg::MAC_IDLE;
                            run_done <= 1'b1;
                        end else begin
                            state <= mvm_types_pkg::MAC_MAC;
                        end
                    end
                end
                default: state <= mvm_types_pkg::MAC_IDLE;
            endcase
        end
    end

endmodule

//--- tile_engine/tile_pingpong_buffer.sv
`timescale 1ns/1ps
`include "mvm_defines.svh"

module tile_pingpong_buffer (
    input  logic clk,
    input  logic rst_n,
    tile_if.buffer tile_bus
);

    localparam int SLOTS = `MVM_TILE_SLOTS;
    localparam int X_BASE = `MVM_TILE * `MVM_TILE;
    localparam int TILE_ROWS = `MVM_ROWS / `MVM_TILE;

    mvm_types_pkg::data_t bank_mem [2][SLOTS];
    mvm_types_pkg::tile_row_t bank_row [2];
    logic [1:0] bank_last;
    logic [1:0] full;
    logic wr_bank;
    logic rd_bank;
    mvm_types_pkg::tile_row_t wr_row;
    logic wr_fire;
    logic wr_done;

    assign tile_bus.wr_ready = !full[wr_bank];
    assign wr_fire = tile_bus.wr_valid && tile_bus.wr_ready;
    assign wr_done = wr_fire && (tile_bus.wr_slot == mvm_types_pkg::slot_t'(SLOTS - 1));

    assign tile_bus.rd_valid = full[rd_bank];
    assign tile_bus.rd_x = bank_mem[rd_bank][X_BASE + tile_bus.rd_col];
    assign tile_bus.rd_last_in_row = bank_last[rd_bank];
    assign tile_bus.rd_tile_row = bank_row[rd_bank];

    // Lane i sees row i of the selected tile column
    always_comb begin
        for (int i = 0; i < `MVM_TILE; i++) begin
            tile_bus.rd_weights[i] = bank_mem[rd_bank][i * `MVM_TILE + tile_bus.rd_col];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bank_mem[wr_bank][tile_bus.wr_slot] <= tile_bus.wr_data;
        end
        if (wr_done) begin
            bank_row[wr_bank] <= wr_row;
            bank_last[wr_bank] <= tile_bus.wr_tile_last_in_row;
        end
    end

    // Banks flip independently on each side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 2'b00;
            wr_bank <= 1'b0;
            rd_bank <= 1'b0;
            wr_row <= '0;
        end else begin
            if (wr_done) begin
                full[wr_bank] <= 1'b1;
                wr_bank <= !wr_bank;
                if (tile_bus.wr_tile_last_in_row) begin
                    wr_row <= (wr_row == mvm_types_pkg::tile_row_t'(TILE_ROWS - 1)) ? '0
                                                                                    : wr_row + 1'b1;
                end
            end
            if (tile_bus.rd_release) begin
                full[rd_bank] <= 1'b0;
                rd_bank <= !rd_bank;
            end
        end
    end

endmodule
